// ==== sources.f ====
+incdir+src
src/tcb_lite_pkg.sv
src/tcb_lite_if.sv
src/tcb_lite_dec.sv
src/tcb_lite_mem.sv
src/tcb_lite_err.sv
src/tcb_lite_csr.sv
src/tcb_lite_sys.sv
tests/tcb_lite_sys_tb.sv

// ==== Makefile ====
# Verilator flow for the TCB-Lite subsystem
# every variable can be overridden, e.g. make sim LOG=run.log

VERILATOR ?= verilator
FILELIST  ?= sources.f
RTL_TOP   ?= tcb_lite_sys
TB_TOP    ?= tcb_lite_sys_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Test FAILED
PASS_MSG  ?= Test OK
VFLAGS    ?= --timing --assert -Wno-fatal

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)

sim: build
	-$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not finish, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/tcb_lite_sys_tb.sv ====
/*
 * TCB-Lite subsystem testbench
 * clock, reset, bus driver, reference model, response checker, timeout
 * directed memory, unmapped, register and memory-disable tests, random traffic
 */

`timescale 1ns/10ps

`include "tcb_lite_params.svh"

module tcb_lite_sys_tb;

    import tcb_lite_pkg::*;

    localparam int       RAND_N      = 400;
    // every transfer takes one cycle, doubled for idles and reset
    localparam int       CYCLE_LIMIT = 2 * (256 + 16 + 64 + RAND_N) + 100;
    localparam int       MEM_END     = `TCB_MEM_DEPTH * `TCB_BEN_W;
    localparam tcb_adr_t A_CTRL      = `TCB_CSR_BASE;
    localparam tcb_adr_t A_SCRATCH   = `TCB_CSR_BASE + 12'd4;
    localparam tcb_adr_t A_ERR_CNT   = `TCB_CSR_BASE + 12'd8;
    localparam tcb_adr_t A_RSVD      = `TCB_CSR_BASE + 12'd12;
    localparam tcb_adr_t A_UNMAP     = `TCB_CSR_BASE + `TCB_CSR_SIZE;

    logic     tcb;
    logic     rst_n;
    logic     vld;
    logic     wen;
    tcb_adr_t adr;
    tcb_ben_t ben;
    tcb_dat_t wdt;
    logic     rdy;
    tcb_dat_t rdt;
    logic     err;

    // model state
    tcb_dat_t    model_mem [`TCB_MEM_DEPTH];
    logic        model_ctrl;
    tcb_dat_t    model_scratch;
    tcb_cnt_t    model_cnt;

    // expected responses in issue order
    logic [32:0] want_q [$];
    string       name_q [$];
    string       test_name;
    integer      seed;
    int          num_checks;
    int          num_errors;
    int          cycles;
    logic        rdy_up;

    tcb_lite_sys tcb_lite_sys_inst (
        .tcb   (tcb),
        .rst_n (rst_n),
        .vld   (vld),
        .wen   (wen),
        .adr   (adr),
        .ben   (ben),
        .wdt   (wdt),
        .rdy   (rdy),
        .rdt   (rdt),
        .err   (err)
    );

    always #5 tcb = ~tcb;

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic tcb_dat_t merge_bytes(input tcb_dat_t old, input tcb_dat_t neu,
                                             input tcb_ben_t be);
        tcb_dat_t res;
        res = old;
        for (int b = 0; b < `TCB_BEN_W; b++) begin
            if (be[b]) res[8*b +: 8] = neu[8*b +: 8];
        end
        return res;
    endfunction

    // returns {err, rdt} and updates the model as the transfer would
    function automatic logic [32:0] ref_xfer(input logic w, input tcb_adr_t a,
                                             input tcb_ben_t be, input tcb_dat_t d);
        tcb_dat_t rd;
        logic     er;
        int       idx;
        rd  = '0;
        er  = 1'b0;
        idx = int'(a) / `TCB_BEN_W;
        if ((int'(a) < MEM_END) && model_ctrl) begin
            if (w) model_mem[idx] = merge_bytes(model_mem[idx], d, be);
            else rd = model_mem[idx];
        end else if ((a >= A_CTRL) && (a < A_UNMAP)) begin
            case (a[3:2])
                2'd0: begin
                    if (!w) rd = tcb_dat_t'(model_ctrl);
                    else if (be[0]) model_ctrl = d[0];
                end
                2'd1: begin
                    if (w) model_scratch = merge_bytes(model_scratch, d, be);
                    else rd = model_scratch;
                end
                2'd2: begin
                    // any write clears the count
                    if (w) model_cnt = '0;
                    else rd = tcb_dat_t'(model_cnt);
                end
                default: rd = '0;
            endcase
        end else begin
            er = 1'b1;
            if (model_cnt != 16'hffff) model_cnt = model_cnt + 16'd1;
        end
        return {er, rd};
    endfunction

    // memory fill, unique per word index
    function automatic tcb_dat_t fill_word(input int idx);
        return tcb_dat_t'(32'hc0de_0000 ^ (idx * 32'h0001_0203));
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // checker and timeout
    ////////////////////////////////////////////////////////////////////////////

    // inputs settle 1 ns after the rising edge, so the falling edge is quiet
    always @(negedge tcb) begin
        logic [32:0] want;
        string       nm;
        // response of the transfer taken at the last rising edge
        if (want_q.size() > 0) begin
            want = want_q.pop_front();
            nm   = name_q.pop_front();
            num_checks++;
            if (rdt !== want[31:0]) begin
                $display("** Error [%s] rdt expected %h actual %h", nm, want[31:0], rdt);
                num_errors++;
            end
            if (err !== want[32]) begin
                $display("** Error [%s] err expected %b actual %b", nm, want[32], err);
                num_errors++;
            end
        end
        if (rst_n) begin
            if (rdy === 1'b1) begin
                rdy_up = 1'b1;
            end else if (rdy_up) begin
                $display("rdy dropped low at cycle %0d although reset is released", cycles);
                num_errors++;
            end
            if (vld && (rdy === 1'b1)) begin
                want_q.push_back(ref_xfer(wen, adr, ben, wdt));
                name_q.push_back(test_name);
            end
        end
    end

    always @(posedge tcb) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout, the run did not end within %0d cycles", CYCLE_LIMIT);
            $display("checks: %0d, errors: %0d", num_checks, num_errors);
            $display("Test FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // driver
    ////////////////////////////////////////////////////////////////////////////

    // holds the request until rdy is seen, returns 1 ns after the accepting edge
    task automatic bus_xfer(input logic w, input tcb_adr_t a, input tcb_ben_t be,
                            input tcb_dat_t d);
        logic taken;
        vld   = 1'b1;
        wen   = w;
        adr   = a;
        ben   = be;
        wdt   = d;
        taken = 1'b0;
        while (!taken) begin
            @(negedge tcb);
            taken = (rdy === 1'b1);
            @(posedge tcb);
            #1;
        end
    endtask

    task automatic bus_idle();
        vld = 1'b0;
        wen = 1'b0;
        @(posedge tcb);
        #1;
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] d;
        tcb_adr_t    a;
        tcb           = 1'b0;
        rst_n         = 1'b0;
        vld           = 1'b0;
        wen           = 1'b0;
        adr           = '0;
        ben           = '0;
        wdt           = '0;
        seed          = 32'h3af2;
        num_checks    = 0;
        num_errors    = 0;
        cycles        = 0;
        rdy_up        = 1'b0;
        model_ctrl    = 1'b1;
        model_scratch = '0;
        model_cnt     = '0;
        repeat (4) @(posedge tcb);
        #1;
        rst_n = 1'b1;

        // whole memory gets a known pattern first
        test_name = "mem_fill";
        for (int i = 0; i < `TCB_MEM_DEPTH; i++) begin
            bus_xfer(1'b1, tcb_adr_t'(i * 4), 4'hf, fill_word(i));
        end

        test_name = "mem_ben";
        for (int i = 0; i < 8; i++) begin
            bus_xfer(1'b1, tcb_adr_t'(12'h040 + i * 4), tcb_ben_t'(i * 5 + 3),
                     32'hdead_be00 | i);
        end
        for (int i = 0; i < 8; i++) begin
            bus_xfer(1'b0, tcb_adr_t'(12'h040 + i * 4), 4'hf, '0);
        end
        bus_idle();

        // error slave has no storage, reads after writes stay zero
        test_name = "unmapped";
        bus_xfer(1'b1, A_UNMAP, 4'hf, 32'h1111_2222);
        bus_xfer(1'b1, 12'h7fc, 4'hf, 32'h3333_4444);
        bus_xfer(1'b1, 12'hffc, 4'h3, 32'h5555_6666);
        bus_xfer(1'b0, A_UNMAP, 4'hf, '0);
        bus_xfer(1'b0, 12'h7fc, 4'hf, '0);
        bus_xfer(1'b0, 12'hffc, 4'hf, '0);
        // words the unmapped writes would hit if the upper address bits were dropped
        bus_xfer(1'b0, 12'h010, 4'hf, '0);
        bus_xfer(1'b0, 12'h3fc, 4'hf, '0);
        bus_xfer(1'b0, A_CTRL, 4'hf, '0);
        bus_idle();

        test_name = "csr";
        bus_xfer(1'b0, A_ERR_CNT, 4'hf, '0);
        bus_xfer(1'b1, A_ERR_CNT, 4'hf, '0);
        bus_xfer(1'b0, A_ERR_CNT, 4'hf, '0);
        bus_xfer(1'b0, 12'h900, 4'hf, '0);
        bus_xfer(1'b1, 12'ha00, 4'hf, 32'h77);
        bus_xfer(1'b0, 12'hb00, 4'hf, '0);
        bus_xfer(1'b0, A_ERR_CNT, 4'hf, '0);
        bus_xfer(1'b1, A_SCRATCH, 4'hf, 32'h1234_5678);
        bus_xfer(1'b1, A_SCRATCH, 4'b0100, 32'h00ab_0000);
        bus_xfer(1'b1, A_SCRATCH, 4'b1001, 32'hcd00_00ef);
        bus_xfer(1'b0, A_SCRATCH, 4'hf, '0);
        bus_xfer(1'b1, A_RSVD, 4'hf, 32'hffff_ffff);
        bus_xfer(1'b0, A_RSVD, 4'hf, '0);
        bus_xfer(1'b0, A_CTRL, 4'hf, '0);
        bus_xfer(1'b1, A_ERR_CNT, 4'h1, '0);
        bus_xfer(1'b0, A_ERR_CNT, 4'hf, '0);
        bus_idle();

        // memory region falls to the error slave while disabled
        test_name = "mem_off";
        bus_xfer(1'b1, A_CTRL, 4'h1, 32'h0);
        bus_xfer(1'b0, A_CTRL, 4'hf, '0);
        bus_xfer(1'b0, 12'h040, 4'hf, '0);
        bus_xfer(1'b1, 12'h044, 4'hf, 32'hbad0_bad0);
        bus_xfer(1'b0, A_ERR_CNT, 4'hf, '0);
        bus_xfer(1'b1, A_CTRL, 4'h1, 32'h1);
        bus_xfer(1'b0, 12'h040, 4'hf, '0);
        bus_xfer(1'b0, 12'h044, 4'hf, '0);
        bus_idle();

        // no idle cycles, region picked by the low random bits
        test_name = "random";
        for (int n = 0; n < RAND_N; n++) begin
            r = $random(seed);
            d = $random(seed);
            if (r[2:0] < 3'd4) begin
                a = {2'b00, r[15:8], 2'b00};
            end else if (r[2:0] < 3'd6) begin
                a = A_CTRL | {8'h00, r[9:8], 2'b00};
            end else begin
                a = {r[27:18], 2'b00};
                if (a < A_UNMAP) a = a | 12'h800;
            end
            bus_xfer(r[3], a, r[7:4], d);
        end
        bus_idle();
        repeat (2) @(negedge tcb);

        $display("checks: %0d, errors: %0d", num_checks, num_errors);
        if (num_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== src/tcb_lite_sys.sv ====
/*
 * TCB-Lite subsystem top
 * plain manager port, decoder, memory, register block, error slave
 */

`timescale 1ns/10ps

module tcb_lite_sys (
    input  logic                   tcb,
    input  logic                   rst_n,
    input  logic                   vld,
    input  logic                   wen,
    input  tcb_lite_pkg::tcb_adr_t adr,
    input  tcb_lite_pkg::tcb_ben_t ben,
    input  tcb_lite_pkg::tcb_dat_t wdt,
    output logic                   rdy,
    output tcb_lite_pkg::tcb_dat_t rdt,
    output logic                   err
);

    import tcb_lite_pkg::*;

    // steering between register block, decoder and error slave
    logic     mem_en;
    logic     err_clr;
    tcb_cnt_t err_cnt;

    tcb_lite_if man_bus (.tcb(tcb), .rst_n(rst_n));
    tcb_lite_if mem_bus (.tcb(tcb), .rst_n(rst_n));
    tcb_lite_if csr_bus (.tcb(tcb), .rst_n(rst_n));
    tcb_lite_if err_bus (.tcb(tcb), .rst_n(rst_n));

    ////////////////////////////////////////////////////////////////////////////
    // manager port onto the bus
    ////////////////////////////////////////////////////////////////////////////

    assign man_bus.vld = vld;
    assign man_bus.wen = wen;
    assign man_bus.adr = adr;
    assign man_bus.ben = ben;
    assign man_bus.wdt = wdt;

    assign rdy = man_bus.rdy;
    assign rdt = man_bus.rdt;
    assign err = man_bus.err;

    ////////////////////////////////////////////////////////////////////////////
    // decoder and subordinates
    ////////////////////////////////////////////////////////////////////////////

    tcb_lite_dec tcb_lite_dec_inst (
        .man    (man_bus),
        .mem    (mem_bus),
        .csr    (csr_bus),
        .err    (err_bus),
        .mem_en (mem_en)
    );

    tcb_lite_mem tcb_lite_mem_inst (
        .tcb (mem_bus)
    );

    tcb_lite_csr tcb_lite_csr_inst (
        .tcb     (csr_bus),
        .err_cnt (err_cnt),
        .mem_en  (mem_en),
        .err_clr (err_clr)
    );

    tcb_lite_err tcb_lite_err_inst (
        .tcb     (err_bus),
        .err_clr (err_clr),
        .err_cnt (err_cnt)
    );

endmodule

// ==== src/tcb_lite_csr.sv ====
/*
 * TCB-Lite register block
 * CTRL with memory enable, SCRATCH, error count view and clear
 */

`timescale 1ns/10ps

module tcb_lite_csr (
    tcb_lite_if.subordinate        tcb,
    input  tcb_lite_pkg::tcb_cnt_t err_cnt,
    output logic                   mem_en,
    output logic                   err_clr
);

    import tcb_lite_pkg::*;

    // word offsets within the region
    localparam logic [1:0] OFS_CTRL    = 2'd0;
    localparam logic [1:0] OFS_SCRATCH = 2'd1;
    localparam logic [1:0] OFS_ERR_CNT = 2'd2;

    logic [1:0] ofs;
    logic       wr;
    logic       rdy_q;
    logic       ctrl_q;
    tcb_dat_t   scratch_q;
    tcb_dat_t   rdt_q;

    assign ofs = tcb.adr[3:2];
    assign wr  = tcb.trn && tcb.wen;

    ////////////////////////////////////////////////////////////////////////////
    // register writes
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge tcb.tcb or negedge tcb.rst_n) begin
        if (!tcb.rst_n) begin
            rdy_q     <= 1'b0;
            ctrl_q    <= 1'b1;
            scratch_q <= '0;
        end else begin
            rdy_q <= 1'b1;
            // mem_en lives in the low byte
            if (wr && (ofs == OFS_CTRL) && tcb.ben[0]) begin
                ctrl_q <= tcb.wdt[0];
            end
            if (wr && (ofs == OFS_SCRATCH)) begin
                for (int b = 0; b < $bits(tcb_ben_t); b++) begin
                    if (tcb.ben[b]) begin
                        scratch_q[8*b +: 8] <= tcb.wdt[8*b +: 8];
                    end
                end
            end
        end
    end

    // read mux, registered on the transfer
    always_ff @(posedge tcb.tcb or negedge tcb.rst_n) begin
        if (!tcb.rst_n) begin
            rdt_q <= '0;
        end else if (tcb.trn) begin
            if (tcb.wen) begin
                rdt_q <= '0;
            end else begin
                case (ofs)
                    OFS_CTRL:    rdt_q <= tcb_dat_t'(ctrl_q);
                    OFS_SCRATCH: rdt_q <= scratch_q;
                    OFS_ERR_CNT: rdt_q <= tcb_dat_t'(err_cnt);
                    default:     rdt_q <= '0;
                endcase
            end
        end
    end

    // any write to ERR_CNT clears the counter in the error slave
    assign err_clr = wr && (ofs == OFS_ERR_CNT);
    assign mem_en  = ctrl_q;

    assign tcb.rdy = rdy_q;
    assign tcb.rdt = rdt_q;
    assign tcb.err = 1'b0;

endmodule

// ==== src/tcb_lite_err.sv ====
/*
 * TCB-Lite default error subordinate
 * always ready, answers with err, counts its transfers
 */

`timescale 1ns/10ps

module tcb_lite_err (
    tcb_lite_if.subordinate     tcb,
    input  logic                err_clr,
    output tcb_lite_pkg::tcb_cnt_t err_cnt
);

    import tcb_lite_pkg::*;

    logic     rdy_q;
    logic     err_q;
    tcb_cnt_t cnt_q;

    always_ff @(posedge tcb.tcb or negedge tcb.rst_n) begin
        if (!tcb.rst_n) begin
            rdy_q <= 1'b0;
            err_q <= 1'b0;
        end else begin
            rdy_q <= 1'b1;
            // error flag one cycle after each transfer
            err_q <= tcb.trn;
        end
    end

    // saturating counter, clear beats a transfer in the same cycle
    always_ff @(posedge tcb.tcb or negedge tcb.rst_n) begin
        if (!tcb.rst_n) begin
            cnt_q <= '0;
        end else if (err_clr) begin
            cnt_q <= '0;
        end else if (tcb.trn && (cnt_q != '1)) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign tcb.rdy = rdy_q;
    assign tcb.rdt = '0;
    assign tcb.err = err_q;
    assign err_cnt = cnt_q;

    a_err_on_trn: assert property (
        @(posedge tcb.tcb) disable iff (!tcb.rst_n)
        tcb.err |-> tcb.trn_dly
    );

endmodule

// ==== src/tcb_lite_mem.sv ====
/*
 * TCB-Lite memory subordinate
 * byte-writable word array with registered read data
 */

`timescale 1ns/10ps

`include "tcb_lite_params.svh"

module tcb_lite_mem (
    tcb_lite_if.subordinate tcb
);

    import tcb_lite_pkg::*;

    // word index bits sit above the byte offset
    localparam int unsigned BYT_AW = $clog2(`TCB_BEN_W);
    localparam int unsigned MEM_AW = $clog2(`TCB_MEM_DEPTH);

    tcb_dat_t                mem [`TCB_MEM_DEPTH];
    logic     [MEM_AW-1:0]   idx;
    tcb_dat_t                rdt_q;
    logic                    rdy_q;

    assign idx = tcb.adr[MEM_AW+BYT_AW-1:BYT_AW];

    // ready from the first clock after reset
    always_ff @(posedge tcb.tcb or negedge tcb.rst_n) begin
        if (!tcb.rst_n) begin
            rdy_q <= 1'b0;
        end else begin
            rdy_q <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////////////////////

    // each byte lane written only under its enable
    always_ff @(posedge tcb.tcb) begin
        if (tcb.trn && tcb.wen) begin
            for (int b = 0; b < `TCB_BEN_W; b++) begin
                if (tcb.ben[b]) begin
                    mem[idx][8*b +: 8] <= tcb.wdt[8*b +: 8];
                end
            end
        end
    end

    // read data captured on the transfer, writes answer with zero
    always_ff @(posedge tcb.tcb or negedge tcb.rst_n) begin
        if (!tcb.rst_n) begin
            rdt_q <= '0;
        end else if (tcb.trn) begin
            rdt_q <= tcb.wen ? '0 : mem[idx];
        end
    end

    assign tcb.rdy = rdy_q;
    assign tcb.rdt = rdt_q;
    // memory never reports an error
    assign tcb.err = 1'b0;

    a_adr_known: assert property (
        @(posedge tcb.tcb) disable iff (!tcb.rst_n)
        tcb.trn |-> !$isunknown(tcb.adr)
    );

endmodule

// ==== src/tcb_lite_dec.sv ====
/*
 * TCB-Lite address decoder
 * region classification, request demultiplexer,
 * select pipeline and response multiplexer
 */

`timescale 1ns/10ps

`include "tcb_lite_params.svh"

module tcb_lite_dec (
    tcb_lite_if.subordinate man,
    tcb_lite_if.manager     mem,
    tcb_lite_if.manager     csr,
    tcb_lite_if.manager     err,
    input  logic            mem_en
);

    import tcb_lite_pkg::*;

    // region limits in bytes
    localparam int unsigned MEM_END = `TCB_MEM_DEPTH * `TCB_BEN_W;
    localparam int unsigned CSR_BEG = `TCB_CSR_BASE;
    localparam int unsigned CSR_END = `TCB_CSR_BASE + `TCB_CSR_SIZE;

    tcb_sel_t sel;
    tcb_sel_t sel_dly [`TCB_DLY];

    // classify the request address, disabled memory falls to the error slave
    always_comb begin
        if (man.adr < MEM_END) begin
            sel = mem_en ? sel_mem : sel_err;
        end else if ((man.adr >= CSR_BEG) && (man.adr < CSR_END)) begin
            sel = sel_csr;
        end else begin
            sel = sel_err;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // request path
    ////////////////////////////////////////////////////////////////////////////

    // only the selected subordinate sees vld
    assign mem.vld = man.vld && (sel == sel_mem);
    assign csr.vld = man.vld && (sel == sel_csr);
    assign err.vld = man.vld && (sel == sel_err);

    // remaining request fields are broadcast
    assign mem.wen = man.wen;
    assign mem.adr = man.adr;
    assign mem.ben = man.ben;
    assign mem.wdt = man.wdt;
    assign csr.wen = man.wen;
    assign csr.adr = man.adr;
    assign csr.ben = man.ben;
    assign csr.wdt = man.wdt;
    assign err.wen = man.wen;
    assign err.adr = man.adr;
    assign err.ben = man.ben;
    assign err.wdt = man.wdt;

    // ready comes back from the addressed subordinate
    always_comb begin
        case (sel)
            sel_mem: man.rdy = mem.rdy;
            sel_csr: man.rdy = csr.rdy;
            default: man.rdy = err.rdy;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // response path
    ////////////////////////////////////////////////////////////////////////////

    // select follows the transfer through the response delay
    always_ff @(posedge man.tcb or negedge man.rst_n) begin
        if (!man.rst_n) begin
            for (int i = 0; i < `TCB_DLY; i++) begin
                sel_dly[i] <= sel_mem;
            end
        end else begin
            sel_dly[0] <= sel;
            for (int i = 1; i < `TCB_DLY; i++) begin
                sel_dly[i] <= sel_dly[i-1];
            end
        end
    end

    // response mux, quiet between transfers
    always_comb begin
        man.rdt = '0;
        man.err = 1'b0;
        if (man.trn_dly) begin
            case (sel_dly[`TCB_DLY-1])
                sel_mem: begin
                    man.rdt = mem.rdt;
                    man.err = mem.err;
                end
                sel_csr: begin
                    man.rdt = csr.rdt;
                    man.err = csr.err;
                end
                default: begin
                    man.rdt = err.rdt;
                    man.err = err.err;
                end
            endcase
        end
    end

    // delayed select names the one subordinate whose response is due
    a_rsp_src: assert property (
        @(posedge man.tcb) disable iff (!man.rst_n)
        man.trn_dly |->
            $onehot({mem.trn_dly, csr.trn_dly, err.trn_dly}) &&
            (((sel_dly[`TCB_DLY-1] == sel_mem) && mem.trn_dly) ||
             ((sel_dly[`TCB_DLY-1] == sel_csr) && csr.trn_dly) ||
             ((sel_dly[`TCB_DLY-1] == sel_err) && err.trn_dly))
    );

endmodule

// ==== src/tcb_lite_if.sv ====
/*
 * TCB-Lite bus interface
 * request and handshake signals, fixed-delay response,
 * delayed transfer flag, manager and subordinate modports
 */

`timescale 1ns/10ps

`include "tcb_lite_params.svh"

interface tcb_lite_if (
    input logic tcb,
    input logic rst_n
);

    import tcb_lite_pkg::*;

    // request, driven by the manager
    logic     vld;
    logic     wen;
    tcb_adr_t adr;
    tcb_ben_t ben;
    tcb_dat_t wdt;

    // handshake and response, driven by the subordinate
    logic     rdy;
    tcb_dat_t rdt;
    logic     err;

    // transfer flag and its delayed copy
    logic                 trn;
    logic                 trn_dly;
    logic [`TCB_DLY-1:0]  trn_pipe;

    ////////////////////////////////////////////////////////////////////////////
    // transfer tracking
    ////////////////////////////////////////////////////////////////////////////

    assign trn = vld & rdy;

    // shift the transfer flag so the response side knows when data is due
    always_ff @(posedge tcb or negedge rst_n) begin
        if (!rst_n) begin
            trn_pipe <= '0;
        end else begin
            trn_pipe[0] <= trn;
            for (int i = 1; i < `TCB_DLY; i++) begin
                trn_pipe[i] <= trn_pipe[i-1];
            end
        end
    end

    // last stage lines up with rdt and err
    assign trn_dly = trn_pipe[`TCB_DLY-1];

    ////////////////////////////////////////////////////////////////////////////
    // modports
    ////////////////////////////////////////////////////////////////////////////

    modport manager (
        input  tcb, rst_n,
        output vld, wen, adr, ben, wdt,
        input  rdy, rdt, err,
        input  trn, trn_dly
    );

    modport subordinate (
        input  tcb, rst_n,
        input  vld, wen, adr, ben, wdt,
        output rdy, rdt, err,
        input  trn, trn_dly
    );

endinterface

// ==== src/tcb_lite_pkg.sv ====
/*
 * TCB-Lite shared types
 * address, data, byte enable, region select and error counter
 */

`include "tcb_lite_params.svh"

package tcb_lite_pkg;

    // byte address
    typedef logic [`TCB_ADR_W-1:0] tcb_adr_t;

    // data word
    typedef logic [`TCB_DAT_W-1:0] tcb_dat_t;

    // one enable per byte lane
    typedef logic [`TCB_BEN_W-1:0] tcb_ben_t;

    // region picked by the decoder
    typedef enum logic [1:0] {
        sel_mem = 2'd0,
        sel_csr = 2'd1,
        sel_err = 2'd2
    } tcb_sel_t;

    // error subordinate transfer counter
    typedef logic [15:0] tcb_cnt_t;

endpackage

// ==== src/tcb_lite_params.svh ====
/*
 * TCB-Lite subsystem parameters
 * bus widths, response delay, memory depth and the address map
 */

`ifndef TCB_LITE_PARAMS_SVH
`define TCB_LITE_PARAMS_SVH

// bus widths
`define TCB_ADR_W 12
`define TCB_DAT_W 32
`define TCB_BEN_W 4

// response delay in cycles, counted from the transfer
`define TCB_DLY 1

// memory size in words, region starts at address 0
`define TCB_MEM_DEPTH 256

// register block region
`define TCB_CSR_BASE 12'h400
`define TCB_CSR_SIZE 16

`endif
